/* verilog/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Machine word, also used for pc and memory addresses
`define XLEN 32

// Integer register file
`define NREGS 32
`define REGAW 5

`endif

/* verilog/rv_pkg.sv */
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    // funct3 in the low bits, bit 3 selects SUB/SRA or a branch compare
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSll  = 4'd1,
        opSlt  = 4'd2,
        opSltu = 4'd3,
        opXor  = 4'd4,
        opSrl  = 4'd5,
        opOr   = 4'd6,
        opAnd  = 4'd7,
        opSub  = 4'd8,
        opBeq  = 4'd9,
        opBne  = 4'd10,
        opBlt  = 4'd11,
        opBge  = 4'd12,
        opSra  = 4'd13,
        opBltu = 4'd14,
        opBgeu = 4'd15
    } aluOp_e;

    typedef struct packed {
        logic [`XLEN-1:0]  imm;       // Sign-extended
        logic [`REGAW-1:0] rs1;
        logic [`REGAW-1:0] rs2;
        logic [`REGAW-1:0] rd;
        aluOp_e            op;
        logic              rdWe;
        logic              memWrite;
        logic [3:0]        memBe;
        logic              noRs1;     // Operand A forced to zero
        logic              useImm;    // Operand B from imm
        logic              isAuipc;
        logic              isLoad;
        logic              isJal;
        logic              isJalr;
        logic              isBranch;
        logic [2:0]        loadFunct;
    } ctrl_t;

    typedef struct packed {
        logic [31:0]      instr;
        logic [`XLEN-1:0] pc;
    } instrBeat_t;

    typedef struct packed {
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  nextPc;
        logic [`REGAW-1:0] rd;
        logic              rdWe;
        logic [`XLEN-1:0]  rdData;
        logic              branchTaken;
        logic              memWrite;
        logic              memRead;
        logic [3:0]        memBe;
        logic [`XLEN-1:0]  memAddr;
        logic [`XLEN-1:0]  memData;
        logic [2:0]        loadFunct;  // Load width and sign, for the memory side
    } result_t;

endpackage

`default_nettype wire

/* verilog/InstrDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module InstrDecoder (
    input  wire logic [31:0] instr,
    output rv_pkg::ctrl_t    ctrl
);
    import rv_pkg::*;

    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    logic [2:0]  funct3;
    logic        altBit;

    assign funct3 = instr[14:12];
    assign altBit = instr[30];  // SUB / SRA select

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'h000};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        ctrl = '0;  // Unknown opcodes fall through with no effects
        case (instr[6:0])
            7'b0110111:  // LUI
            begin
                ctrl.imm    = immU;
                ctrl.rd     = instr[11:7];
                ctrl.rdWe   = 1'b1;
                ctrl.noRs1  = 1'b1;
                ctrl.useImm = 1'b1;
            end
            7'b0010111:  // AUIPC
            begin
                ctrl.imm     = immU;
                ctrl.rd      = instr[11:7];
                ctrl.rdWe    = 1'b1;
                ctrl.noRs1   = 1'b1;
                ctrl.useImm  = 1'b1;
                ctrl.isAuipc = 1'b1;
            end
            7'b1101111:  // JAL
            begin
                ctrl.imm    = immJ;
                ctrl.rd     = instr[11:7];
                ctrl.rdWe   = 1'b1;
                ctrl.noRs1  = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.isJal  = 1'b1;
            end
            7'b1100111:  // JALR
            begin
                ctrl.imm    = immI;
                ctrl.rs1    = instr[19:15];
                ctrl.rd     = instr[11:7];
                ctrl.rdWe   = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.isJalr = 1'b1;
            end
            7'b1100011:  // Branches
            begin
                ctrl.imm      = immB;
                ctrl.rs1      = instr[19:15];
                ctrl.rs2      = instr[24:20];
                ctrl.isBranch = 1'b1;
                case (funct3)
                    3'b000:  ctrl.op = opBeq;
                    3'b001:  ctrl.op = opBne;
                    3'b100:  ctrl.op = opBlt;
                    3'b101:  ctrl.op = opBge;
                    3'b110:  ctrl.op = opBltu;
                    3'b111:  ctrl.op = opBgeu;
                    default: ctrl.op = opAdd;  // Never taken
                endcase
            end
            7'b0000011:  // Loads
            begin
                ctrl.imm       = immI;
                ctrl.rs1       = instr[19:15];
                ctrl.rd        = instr[11:7];
                ctrl.rdWe      = 1'b1;
                ctrl.useImm    = 1'b1;
                ctrl.isLoad    = 1'b1;
                ctrl.loadFunct = funct3;
            end
            7'b0100011:  // Stores
            begin
                ctrl.imm      = immS;
                ctrl.rs1      = instr[19:15];
                ctrl.rs2      = instr[24:20];
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.memBe = 4'b0001;
                    3'b001:  ctrl.memBe = 4'b0011;
                    3'b010:  ctrl.memBe = 4'b1111;
                    default: ctrl.memBe = 4'b0000;
                endcase
            end
            7'b0010011:  // OP-IMM
            begin
                ctrl.imm    = immI;
                ctrl.rs1    = instr[19:15];
                ctrl.rd     = instr[11:7];
                ctrl.rdWe   = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.op     = aluOp_e'({funct3 == 3'b101 && altBit, funct3});
            end
            7'b0110011:  // OP
            begin
                ctrl.rs1  = instr[19:15];
                ctrl.rs2  = instr[24:20];
                ctrl.rd   = instr[11:7];
                ctrl.rdWe = 1'b1;
                ctrl.op   = aluOp_e'({(funct3 == 3'b000 || funct3 == 3'b101) && altBit, funct3});
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/RegFile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module RegFile (
    input  wire logic              clk,
    input  wire logic              arstN,
    input  wire logic [`REGAW-1:0] rs1,
    input  wire logic [`REGAW-1:0] rs2,
    output logic      [`XLEN-1:0]  rs1Data,
    output logic      [`XLEN-1:0]  rs2Data,
    input  wire logic              we,
    input  wire logic [`REGAW-1:0] rd,
    input  wire logic [`XLEN-1:0]  rdData
);

    logic [`XLEN-1:0] regs [`NREGS];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we)
        begin
            regs[rd] <= rdData;
        end
    end

    // x0 reads zero whatever was stored
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* verilog/Alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module Alu (
    input  wire rv_pkg::aluOp_e   op,
    input  wire logic [`XLEN-1:0] a,
    input  wire logic [`XLEN-1:0] b,
    output logic      [`XLEN-1:0] y,
    output logic                  taken
);
    import rv_pkg::*;

    localparam int ShW = $clog2(`XLEN);

    logic [ShW-1:0] shamt;
    logic           ltSigned;
    logic           ltUnsigned;
    logic           equal;

    assign shamt      = b[ShW-1:0];
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;
    assign equal      = a == b;

    always_comb
    begin
        y     = '0;
        taken = 1'b0;
        case (op)
            opAdd:  y = a + b;
            opSub:  y = a - b;
            opSll:  y = a << shamt;
            opSlt:  y = {{(`XLEN-1){1'b0}}, ltSigned};
            opSltu: y = {{(`XLEN-1){1'b0}}, ltUnsigned};
            opXor:  y = a ^ b;
            opSrl:  y = a >> shamt;
            opSra:  y = $signed(a) >>> shamt;
            opOr:   y = a | b;
            opAnd:  y = a & b;
            // Compares only, y unused by the core
            opBeq:  taken = equal;
            opBne:  taken = !equal;
            opBlt:  taken = ltSigned;
            opBge:  taken = !ltSigned;
            opBltu: taken = ltUnsigned;
            opBgeu: taken = !ltUnsigned;
            default:
            begin
                y     = '0;
                taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/PipeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module PipeStage #(
    parameter type T = logic
) (
    input  wire logic clk,
    input  wire logic arstN,
    input  wire logic inValid,
    output logic      inReady,
    input  wire T     inData,
    output logic      outValid,
    input  wire logic outReady,
    output T          outData
);

    // Takes a new entry when empty or when the held one leaves this cycle
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            outValid <= 1'b0;
        else if (inReady)
            outValid <= inValid;
    end

    always_ff @(posedge clk)
    begin
        if (inValid && inReady)
            outData <= inData;
    end

endmodule

`default_nettype wire

/* verilog/ExecCore.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module ExecCore (
    input  wire logic               clk,
    input  wire logic               arstN,
    input  wire logic               inValid,
    output logic                    inReady,
    input  wire rv_pkg::instrBeat_t inBeat,
    output logic                    outValid,
    input  wire logic               outReady,
    output rv_pkg::result_t         outResult
);
    import rv_pkg::*;

    instrBeat_t       decBeat;
    logic             decValid;
    logic             resReady;
    ctrl_t            ctrl;
    result_t          res;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluY;
    logic             aluTaken;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcPlusImm;
    logic [`XLEN-1:0] rs1PlusImm;
    logic             regWe;

    PipeStage #(.T(instrBeat_t)) i_decStage (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inBeat),
        .outValid (decValid),
        .outReady (resReady),
        .outData  (decBeat)
    );

    InstrDecoder i_decoder (
        .instr (decBeat.instr),
        .ctrl  (ctrl)
    );

    // Write lands on the edge the record moves on, so the next beat sees it
    assign regWe = decValid && resReady && res.rdWe && (ctrl.rd != '0);

    RegFile i_regFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1     (ctrl.rs1),
        .rs2     (ctrl.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .we      (regWe),
        .rd      (ctrl.rd),
        .rdData  (res.rdData)
    );

    assign opA = ctrl.noRs1 ? '0 : rs1Data;
    assign opB = ctrl.useImm ? ctrl.imm : rs2Data;

    Alu i_alu (
        .op    (ctrl.op),
        .a     (opA),
        .b     (opB),
        .y     (aluY),
        .taken (aluTaken)
    );

    assign pcPlus4    = decBeat.pc + `XLEN'd4;
    assign pcPlusImm  = decBeat.pc + ctrl.imm;
    assign rs1PlusImm = rs1Data + ctrl.imm;

    always_comb
    begin
        res             = '0;
        res.pc          = decBeat.pc;
        res.rd          = ctrl.rd;
        res.rdWe        = ctrl.rdWe && !ctrl.isLoad;  // Load data is not returned here
        res.branchTaken = ctrl.isBranch && aluTaken;
        res.memWrite    = ctrl.memWrite;
        res.memRead     = ctrl.isLoad;
        res.memBe       = ctrl.memBe;
        res.memAddr     = rs1PlusImm;
        res.memData     = rs2Data;
        res.loadFunct   = ctrl.loadFunct;

        if (ctrl.isAuipc)
            res.rdData = pcPlusImm;
        else if (ctrl.isJal || ctrl.isJalr)
            res.rdData = pcPlus4;
        else
            res.rdData = aluY;  // LUI arrives as 0 + imm

        if (ctrl.isJal || res.branchTaken)
            res.nextPc = pcPlusImm;
        else if (ctrl.isJalr)
            res.nextPc = {rs1PlusImm[`XLEN-1:1], 1'b0};
        else
            res.nextPc = pcPlus4;
    end

    PipeStage #(.T(result_t)) i_resStage (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (decValid),
        .inReady  (resReady),
        .inData   (res),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outResult)
    );

endmodule

`default_nettype wire

/* sim/ClockGen.sv */
`timescale 1ns/1ns
`default_nettype none

module ClockGen (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

endmodule

`default_nettype wire

/* sim/ExecCoreTb.sv */
`timescale 1ns/1ns
`default_nettype none

module ExecCoreTb;
    import rv_pkg::*;

    logic        clk;
    logic        arstN    = 1'b0;
    logic        inValid  = 1'b0;
    logic        inReady;
    instrBeat_t  inBeat   = '0;
    logic        outValid;
    logic        outReady = 1'b0;
    result_t     outResult;

    instrBeat_t  beats [$];
    result_t     expected [$];
    int unsigned randState = 19;
    int          cycles;
    int          numOut;
    bit          stalled;  // Record held back at the last sample
    result_t     heldResult;

    ClockGen i_clkGen (.clk(clk));

    ExecCore i_dut (
        .clk       (clk),
        .arstN     (arstN),
        .inValid   (inValid),
        .inReady   (inReady),
        .inBeat    (inBeat),
        .outValid  (outValid),
        .outReady  (outReady),
        .outResult (outResult)
    );

    function automatic int unsigned nextRandom();
        randState = randState * 1103515245 + 12345;
        return randState >> 16;
    endfunction

    // Record of an instruction with no memory request
    function automatic result_t makeResult(int pc, int nextPc, int rd, int rdWe, int rdData,
                                           int taken);
        result_t r;
        r             = '0;
        r.pc          = pc;
        r.nextPc      = nextPc;
        r.rd          = rd[4:0];
        r.rdWe        = rdWe[0];
        r.rdData      = rdData;
        r.branchTaken = taken[0];
        return r;
    endfunction

    function automatic result_t withMemReq(result_t r, int write, int be, int addr, int data,
                                           int loadFunct);
        r.memWrite  = write[0];
        r.memRead   = !write[0];
        r.memBe     = be[3:0];
        r.memAddr   = addr;
        r.memData   = data;
        r.loadFunct = loadFunct[2:0];
        return r;
    endfunction

    task automatic addEntry(input int instr, input result_t exp);
        instrBeat_t b;
        b.instr = instr;
        b.pc    = exp.pc;
        beats.push_back(b);
        expected.push_back(exp);
    endtask

    task automatic reportError(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "Check failed");
    endtask

    task automatic checkIdle(input logic expInReady, input logic expOutValid);
        if (inReady !== expInReady || outValid !== expOutValid)
            reportError($sformatf("inReady=%b outValid=%b after reset, expected %b and %b",
                                  inReady, outValid, expInReady, expOutValid));
    endtask

    task automatic checkResult(input result_t got, input result_t exp, input int idx);
        result_t mask;
        mask = '1;
        if (!exp.rdWe)
            mask.rdData = '0;
        if (!exp.memWrite && !exp.memRead)
            mask.memAddr = '0;  // Address and data only matter for a memory request
        if (!exp.memWrite)
            mask.memData = '0;
        if ((got & mask) !== (exp & mask))
            reportError($sformatf("record %0d at pc %h is %h, expected %h",
                                  idx, exp.pc, got, exp));
    endtask

    task automatic buildTable();
        addEntry('h00500093, makeResult('h00, 'h04, 1, 1, 5, 0));           // addi x1,x0,5
        addEntry('hFFD00113, makeResult('h04, 'h08, 2, 1, 'hFFFFFFFD, 0));   // addi x2,x0,-3
        addEntry('h123451B7, makeResult('h08, 'h0C, 3, 1, 'h12345000, 0));
        addEntry('h00001217, makeResult('h0C, 'h10, 4, 1, 'h0000100C, 0));   // auipc x4,1
        addEntry('h002082B3, makeResult('h10, 'h14, 5, 1, 2, 0));
        addEntry('h40208333, makeResult('h14, 'h18, 6, 1, 8, 0));           // sub x6,x1,x2
        addEntry('h001123B3, makeResult('h18, 'h1C, 7, 1, 1, 0));
        addEntry('h00113433, makeResult('h1C, 'h20, 8, 1, 0, 0));           // sltu
        addEntry('h0011C4B3, makeResult('h20, 'h24, 9, 1, 'h12345005, 0));
        addEntry('h00126533, makeResult('h24, 'h28, 10, 1, 'h100D, 0));
        addEntry('h0021F5B3, makeResult('h28, 'h2C, 11, 1, 'h12345000, 0));
        addEntry('h00609633, makeResult('h2C, 'h30, 12, 1, 'h500, 0));      // sll by x6
        addEntry('h001156B3, makeResult('h30, 'h34, 13, 1, 'h07FFFFFF, 0));
        addEntry('h40115733, makeResult('h34, 'h38, 14, 1, 'hFFFFFFFF, 0));  // sra
        addEntry('hFFE12793, makeResult('h38, 'h3C, 15, 1, 1, 0));          // slti x15,x2,-2
        addEntry('h0F01C813, makeResult('h3C, 'h40, 16, 1, 'h123450F0, 0));
        addEntry('h40115893, makeResult('h40, 'h44, 17, 1, 'hFFFFFFFE, 0));  // srai x17,x2,1
        addEntry('h00788013, makeResult('h44, 'h48, 0, 1, 5, 0));           // Write to x0
        addEntry('h00100933, makeResult('h48, 'h4C, 18, 1, 5, 0));
        // Branches with x1 = 5 and x2 = -3
        addEntry('h00108863, makeResult('h4C, 'h5C, 0, 0, 0, 1));           // beq
        addEntry('h00109863, makeResult('h50, 'h54, 0, 0, 0, 0));
        addEntry('hFE114CE3, makeResult('h54, 'h4C, 0, 0, 0, 1));           // blt back
        addEntry('h00115463, makeResult('h58, 'h5C, 0, 0, 0, 0));
        addEntry('h0220E063, makeResult('h5C, 'h7C, 0, 0, 0, 1));           // bltu
        addEntry('h0220F063, makeResult('h60, 'h64, 0, 0, 0, 0));
        addEntry('hFE2098E3, makeResult('h64, 'h54, 0, 0, 0, 1));           // bne back
        addEntry('h00208463, makeResult('h68, 'h6C, 0, 0, 0, 0));
        addEntry('h0020D463, makeResult('h6C, 'h74, 0, 0, 0, 1));
        addEntry('h0020C463, makeResult('h70, 'h74, 0, 0, 0, 0));
        addEntry('h00116463, makeResult('h74, 'h78, 0, 0, 0, 0));
        addEntry('h00117463, makeResult('h78, 'h80, 0, 0, 0, 1));           // bgeu
        addEntry('h001009EF, makeResult('h7C, 'h87C, 19, 1, 'h80, 0));      // jal x19
        addEntry('h00718A67, makeResult('h80, 'h12345006, 20, 1, 'h84, 0)); // jalr clears bit 0
        addEntry('hFFDFF06F, makeResult('h84, 'h80, 0, 1, 'h88, 0));        // jal x0,-4
        addEntry('h00006AB3, makeResult('h88, 'h8C, 21, 1, 0, 0));          // x0 still zero
        addEntry('h010081A3,
                 withMemReq(makeResult('h8C, 'h90, 0, 0, 0, 0), 1, 'b0001, 'h8, 'h123450F0, 0));
        addEntry('hFE219F23,
                 withMemReq(makeResult('h90, 'h94, 0, 0, 0, 0), 1, 'b0011, 'h12344FFE,
                            'hFFFFFFFD, 0));
        addEntry('h0430A023,
                 withMemReq(makeResult('h94, 'h98, 0, 0, 0, 0), 1, 'b1111, 'h45, 'h12345000, 0));
        addEntry('h0041AB03,
                 withMemReq(makeResult('h98, 'h9C, 22, 0, 0, 0), 0, 0, 'h12345004, 0, 2));
        addEntry('hFFF0CB83,
                 withMemReq(makeResult('h9C, 'hA0, 23, 0, 0, 0), 0, 0, 'h4, 0, 4));
        addEntry('h000B0C33, makeResult('hA0, 'hA4, 24, 1, 0, 0));          // Load wrote nothing
    endtask

    initial
    begin
        buildTable();
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkIdle(1'b1, 1'b0);
        @(posedge clk);
        for (int i = 0; i < beats.size(); i++)
        begin
            inValid <= 1'b1;
            inBeat  <= beats[i];
            @(negedge clk);
            while (!inReady)
                @(negedge clk);
            @(posedge clk);  // Beat taken here
        end
        inValid <= 1'b0;
        while (numOut < expected.size())
            @(negedge clk);
        repeat (4) @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

    // Output back-pressure with ready about 60% of cycles
    always @(posedge clk)
        outReady <= (nextRandom() % 100) < 60;

    always @(negedge clk)
    begin
        if (arstN)
        begin
            if (stalled && (!outValid || outResult !== heldResult))
                reportError("output record changed or dropped while stalled");
            if (outValid && outReady)
            begin
                if (numOut >= expected.size())
                    reportError("more records than table entries");
                else
                begin
                    checkResult(outResult, expected[numOut], numOut);
                    numOut++;
                end
            end
            stalled    = outValid && !outReady;
            heldResult = outResult;
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > 20 * expected.size() + 50)
        begin
            $display("Simulation timed out after %0d cycles with %0d of %0d records seen",
                     cycles, numOut, expected.size());
            $display("TEST FAIL");
            $fatal(1, "Timeout");
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/rv_pkg.sv
verilog/InstrDecoder.sv
verilog/RegFile.sv
verilog/Alu.sv
verilog/PipeStage.sv
verilog/ExecCore.sv
sim/ClockGen.sv
sim/ExecCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the ExecCore testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module ExecCoreTb --Mdir build -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./build/VExecCoreTb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
